//--- project.f
verilog/int_rs_pkg.sv
verilog/cdb_itf.sv
verilog/rs_entry.sv
verilog/rs_alloc.sv
verilog/int_rs_ordered.sv
verilog/int_prf.sv
verilog/fu_alu.sv
verilog/int_exec_top.sv
verif/int_exec_tb.sv

//--- verif/int_exec_tb.sv
module int_exec_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;
    localparam int ROW_BUDGET   = 40;

    typedef enum logic [1:0] {
        ROW_LOAD,
        ROW_DISP,
        ROW_DEFER,
        ROW_DRAIN
    } row_kind_t;

    typedef struct packed {
        int_rs_pkg::alu_op_t            op;
        logic [int_rs_pkg::PHY_IDX-1:0] rs1;
        logic [int_rs_pkg::PHY_IDX-1:0] rs2;
        int_rs_pkg::op2_sel_t           sel;
        logic [int_rs_pkg::XLEN-1:0]    imm;
        logic [int_rs_pkg::PHY_IDX-1:0] rd;
    } uop_t;

    typedef struct packed {
        row_kind_t                      kind;
        logic                           ld_en;
        logic [int_rs_pkg::PHY_IDX-1:0] ld_tag;
        logic [int_rs_pkg::XLEN-1:0]    ld_val;
        logic [7:0]                     delay;
        logic [1:0]                     en;
        uop_t                           u0;
        uop_t                           u1;
    } row_t;

    logic                                  clk = 1'b0;
    logic                                  rst;
    logic [int_rs_pkg::DISPATCH_WIDTH-1:0] disp_valid;
    int_rs_pkg::rs_entry_t                 disp_uop [int_rs_pkg::DISPATCH_WIDTH];
    logic                                  disp_ready;
    logic                                  ld_valid;
    logic [int_rs_pkg::ROB_IDX-1:0]        ld_rob_id;
    logic [int_rs_pkg::PHY_IDX-1:0]        ld_rd_phy;
    logic [int_rs_pkg::XLEN-1:0]           ld_value;
    logic                                  result_valid;
    logic [int_rs_pkg::ROB_IDX-1:0]        result_rob_id;
    logic [int_rs_pkg::PHY_IDX-1:0]        result_rd_phy;
    logic [int_rs_pkg::XLEN-1:0]           result_value;

    // scoreboard state
    row_t        rows [$];
    uop_t        uops [$];
    bit          ready_at_disp [$];
    bit          done [32];
    bit [31:0]   model_regs [int_rs_pkg::PHY_REGS];
    bit          known [int_rs_pkg::PHY_REGS];
    int          result_count;
    int          mismatch_count;
    int          fail_count;
    int          last_ready_rob = -1;
    bit          prev_disp;
    bit          burst_mode;
    bit          saw_stall;
    int          defer_cnt;
    row_t        defer_load;
    logic [31:0] rng_state = 32'h2d8b44dd;

    int_exec_top dut (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_uop      (disp_uop),
        .disp_ready    (disp_ready),
        .ld_valid      (ld_valid),
        .ld_rob_id     (ld_rob_id),
        .ld_rd_phy     (ld_rd_phy),
        .ld_value      (ld_value),
        .result_valid  (result_valid),
        .result_rob_id (result_rob_id),
        .result_rd_phy (result_rd_phy),
        .result_value  (result_value)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // model and table helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] alu_model(int_rs_pkg::alu_op_t op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            int_rs_pkg::ALU_ADD: return a + b;
            int_rs_pkg::ALU_SUB: return a - b;
            int_rs_pkg::ALU_AND: return a & b;
            int_rs_pkg::ALU_OR:  return a | b;
            int_rs_pkg::ALU_XOR: return a ^ b;
            int_rs_pkg::ALU_SLL: return a << b[4:0];
            int_rs_pkg::ALU_SRL: return a >> b[4:0];
            int_rs_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic uop_t reg_uop(int_rs_pkg::alu_op_t op, logic [5:0] rs1, logic [5:0] rs2,
                                     logic [5:0] rd);
        return '{op, rs1, rs2, int_rs_pkg::OP2_REG, 32'd0, rd};
    endfunction

    function automatic uop_t imm_uop(int_rs_pkg::alu_op_t op, logic [5:0] rs1, logic [31:0] imm,
                                     logic [5:0] rd);
        return '{op, rs1, 6'd0, int_rs_pkg::OP2_IMM, imm, rd};
    endfunction

    function automatic row_t load_row(logic [5:0] tag, logic [31:0] val);
        row_t r;
        r        = '0;
        r.kind   = ROW_LOAD;
        r.ld_tag = tag;
        r.ld_val = val;
        return r;
    endfunction

    function automatic row_t pair_row(logic [1:0] en, uop_t a, uop_t b);
        row_t r;
        r      = '0;
        r.kind = ROW_DISP;
        r.en   = en;
        r.u0   = a;
        r.u1   = b;
        return r;
    endfunction

    // load strobe in the same cycle as the dispatch
    function automatic row_t pair_load_row(logic [5:0] tag, logic [31:0] val, uop_t a, uop_t b);
        row_t r;
        r        = pair_row(2'b11, a, b);
        r.ld_en  = 1'b1;
        r.ld_tag = tag;
        r.ld_val = val;
        return r;
    endfunction

    function automatic row_t defer_row(logic [5:0] tag, logic [31:0] val, logic [7:0] delay);
        row_t r;
        r       = load_row(tag, val);
        r.kind  = ROW_DEFER;
        r.delay = delay;
        return r;
    endfunction

    function automatic row_t drain_row();
        row_t r;
        r      = '0;
        r.kind = ROW_DRAIN;
        return r;
    endfunction

    task automatic build_table();
        rows.push_back(load_row(6'd1, 32'h0000_1234));
        rows.push_back(load_row(6'd2, 32'hffff_fff0));
        rows.push_back(load_row(6'd3, 32'h0000_0005));
        // all opcodes, ready at dispatch
        rows.push_back(pair_row(2'b11, reg_uop(int_rs_pkg::ALU_ADD, 6'd1, 6'd2, 6'd10),
                                       reg_uop(int_rs_pkg::ALU_SUB, 6'd1, 6'd2, 6'd11)));
        rows.push_back(pair_row(2'b11, imm_uop(int_rs_pkg::ALU_AND, 6'd1, 32'h0f0f, 6'd12),
                                       reg_uop(int_rs_pkg::ALU_OR, 6'd2, 6'd3, 6'd13)));
        rows.push_back(pair_row(2'b11, imm_uop(int_rs_pkg::ALU_XOR, 6'd1, 32'hffff_0000, 6'd14),
                                       reg_uop(int_rs_pkg::ALU_SLL, 6'd1, 6'd3, 6'd15)));
        rows.push_back(pair_row(2'b11, imm_uop(int_rs_pkg::ALU_SRL, 6'd2, 32'h24, 6'd16),
                                       reg_uop(int_rs_pkg::ALU_SLT, 6'd2, 6'd1, 6'd17)));
        rows.push_back(pair_row(2'b11, imm_uop(int_rs_pkg::ALU_SLT, 6'd1, 32'hffff_ffff, 6'd18),
                                       imm_uop(int_rs_pkg::ALU_SLL, 6'd3, 32'd31, 6'd19)));
        // dependent chains
        rows.push_back(pair_row(2'b11, imm_uop(int_rs_pkg::ALU_ADD, 6'd10, 32'd1, 6'd20),
                                       reg_uop(int_rs_pkg::ALU_SUB, 6'd20, 6'd1, 6'd21)));
        rows.push_back(pair_row(2'b11, reg_uop(int_rs_pkg::ALU_XOR, 6'd21, 6'd20, 6'd22),
                                       imm_uop(int_rs_pkg::ALU_OR, 6'd22, 32'h100, 6'd23)));
        // sources that wait on later loads
        rows.push_back(pair_row(2'b11, reg_uop(int_rs_pkg::ALU_ADD, 6'd30, 6'd3, 6'd24),
                                       imm_uop(int_rs_pkg::ALU_SRL, 6'd31, 32'd3, 6'd25)));
        rows.push_back(load_row(6'd30, 32'h8000_0001));
        rows.push_back(pair_load_row(6'd32, 32'h0f0f_f0f0,
                                     reg_uop(int_rs_pkg::ALU_AND, 6'd32, 6'd30, 6'd26),
                                     imm_uop(int_rs_pkg::ALU_ADD, 6'd32, 32'd7, 6'd27)));
        rows.push_back(load_row(6'd31, 32'h0000_0400));
        // burst behind one delayed load
        rows.push_back(drain_row());
        rows.push_back(defer_row(6'd40, 32'h0000_0003, 8'd30));
        for (int k = 0; k < 5; k++) begin
            rows.push_back(pair_row(2'b11,
                imm_uop(int_rs_pkg::ALU_ADD, 6'd40, 32'(k), 6'(41 + 2 * k)),
                imm_uop(int_rs_pkg::ALU_SLL, 6'd40, 32'(k), 6'(42 + 2 * k))));
        end
        rows.push_back(pair_row(2'b11, reg_uop(int_rs_pkg::ALU_SUB, 6'd41, 6'd50, 6'd51),
                                       reg_uop(int_rs_pkg::ALU_SLT, 6'd50, 6'd41, 6'd52)));
        rows.push_back(pair_row(2'b10, reg_uop(int_rs_pkg::ALU_ADD, 6'd0, 6'd0, 6'd0),
                                       imm_uop(int_rs_pkg::ALU_SLT, 6'd51, 32'd0, 6'd53)));
    endtask

    ////////////////////////////////////////
    // driving and checking
    ////////////////////////////////////////

    task automatic drive_load(logic [5:0] tag, logic [31:0] val);
        ld_valid        <= 1'b1;
        ld_rob_id       <= int_rs_pkg::ROB_IDX'(tag);
        ld_rd_phy       <= tag;
        ld_value        <= val;
        model_regs[tag] = val;
    endtask

    task automatic check_result(int rob, logic [5:0] rd, logic [31:0] value);
        uop_t        u;
        bit          fresh;
        logic [31:0] expected;
        fresh = rob < uops.size() && !done[rob];
        assert (fresh) else begin
            fail_count++;
            $display("result at %0t for rob_id %0d that is unknown or already done", $time, rob);
        end
        if (fresh) begin
            u = uops[rob];
            assert (known[u.rs1] && (u.sel == int_rs_pkg::OP2_IMM || known[u.rs2])) else begin
                fail_count++;
                $display("rob_id %0d issued before its sources were written", rob);
            end
            expected = alu_model(u.op, model_regs[u.rs1],
                                 (u.sel == int_rs_pkg::OP2_IMM) ? u.imm : model_regs[u.rs2]);
            assert (rd == u.rd && value == expected) else begin
                mismatch_count++;
                $display("MISMATCH at %0t: rob_id %0d gave rd_phy %0d value %h, expected %0d %h",
                         $time, rob, rd, value, u.rd, expected);
            end
            // ready micro-ops leave oldest first
            if (ready_at_disp[rob]) begin
                assert (rob > last_ready_rob) else begin
                    fail_count++;
                    $display("rob_id %0d completed after a younger ready micro-op", rob);
                end
                last_ready_rob = rob;
            end
            done[rob]        = 1'b1;
            model_regs[u.rd] = expected;
            known[u.rd]      = 1'b1;
            result_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        if (result_valid) begin
            check_result(int'(result_rob_id), result_rd_phy, result_value);
        end
        if (ld_valid) begin
            known[ld_rd_phy] = 1'b1;
        end
        prev_disp = |disp_valid;
        // station count is exact while the burst waits
        if (burst_mode && !prev_disp) begin
            if (!disp_ready) begin
                saw_stall = 1'b1;
            end
            if (uops.size() - result_count > int_rs_pkg::RS_DEPTH - 2) begin
                assert (!disp_ready) else begin
                    mismatch_count++;
                    $display("MISMATCH at %0t: disp_ready high with %0d entries held",
                             $time, uops.size() - result_count);
                end
            end
        end
        disp_valid <= '0;
        ld_valid   <= 1'b0;
        if (defer_cnt > 0) begin
            defer_cnt--;
            if (defer_cnt == 0) begin
                drive_load(defer_load.ld_tag, defer_load.ld_val);
                burst_mode = 1'b0;
            end
        end
    endtask

    // disp_ready is only current after a cycle without a strobe
    task automatic wait_dispatch_slot();
        next_cycle();
        while (prev_disp || !disp_ready) begin
            next_cycle();
        end
    endtask

    task automatic dispatch_slot(int w, uop_t u);
        int_rs_pkg::rs_entry_t e;
        e           = '0;
        e.rob_id    = int_rs_pkg::ROB_IDX'(uops.size());
        e.rs1_phy   = u.rs1;
        e.rs1_ready = known[u.rs1];
        e.rs2_phy   = u.rs2;
        e.rs2_ready = (u.sel == int_rs_pkg::OP2_IMM) || known[u.rs2];
        e.rd_phy    = u.rd;
        e.rd_arch   = u.rd[int_rs_pkg::ARCH_IDX-1:0];
        e.op2_sel   = u.sel;
        e.imm       = u.imm;
        e.op        = u.op;
        uops.push_back(u);
        ready_at_disp.push_back(e.rs1_ready && e.rs2_ready);
        disp_uop[w]   <= e;
        disp_valid[w] <= 1'b1;
    endtask

    task automatic apply_row(row_t r);
        case (r.kind)
            ROW_LOAD: begin
                next_cycle();
                drive_load(r.ld_tag, r.ld_val);
            end
            ROW_DISP: begin
                wait_dispatch_slot();
                if (r.ld_en) begin
                    drive_load(r.ld_tag, r.ld_val);
                end
                if (r.en[0]) begin
                    dispatch_slot(0, r.u0);
                end
                if (r.en[1]) begin
                    dispatch_slot(1, r.u1);
                end
            end
            ROW_DEFER: begin
                defer_load = r;
                defer_cnt  = r.delay;
                burst_mode = 1'b1;
            end
            default: begin
                while (result_count < uops.size()) begin
                    next_cycle();
                end
            end
        endcase
    endtask

    initial begin
        rst         = 1'b1;
        disp_valid  = '0;
        disp_uop[0] = '0;
        disp_uop[1] = '0;
        ld_valid    = 1'b0;
        ld_rob_id   = '0;
        ld_rd_phy   = '0;
        ld_value    = '0;
        build_table();
        for (int c = 0; c <= RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c > 0) begin
                assert (result_valid === 1'b0 && disp_ready === 1'b1) else begin
                    mismatch_count++;
                    $display("MISMATCH at %0t: result_valid %b disp_ready %b around reset",
                             $time, result_valid, disp_ready);
                end
            end
            if (c == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
        end
        foreach (rows[i]) begin
            apply_row(rows[i]);
            rng_state = xorshift32(rng_state);
            repeat (rng_state % 3) next_cycle();
        end
        while (result_count < uops.size() || defer_cnt > 0) begin
            next_cycle();
        end
        // catch stray results
        repeat (4) next_cycle();
        assert (saw_stall) else begin
            fail_count++;
            $display("disp_ready never fell while the burst filled the station");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (rows.size() > 0);
        #((RESET_CYCLES + ROW_BUDGET * rows.size()) * 10);
        fail_count++;
        $display("timeout: run did not finish within %0d cycles",
                 RESET_CYCLES + ROW_BUDGET * rows.size());
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verilog/int_exec_top.sv
module int_exec_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [int_rs_pkg::DISPATCH_WIDTH-1:0] disp_valid,
    input  int_rs_pkg::rs_entry_t                 disp_uop [int_rs_pkg::DISPATCH_WIDTH],
    output logic                                  disp_ready,
    input  logic                                  ld_valid,
    input  logic [int_rs_pkg::ROB_IDX-1:0]        ld_rob_id,
    input  logic [int_rs_pkg::PHY_IDX-1:0]        ld_rd_phy,
    input  logic [int_rs_pkg::XLEN-1:0]           ld_value,
    output logic                                  result_valid,
    output logic [int_rs_pkg::ROB_IDX-1:0]        result_rob_id,
    output logic [int_rs_pkg::PHY_IDX-1:0]        result_rd_phy,
    output logic [int_rs_pkg::XLEN-1:0]           result_value
);

    cdb_itf cdb [int_rs_pkg::CDB_WIDTH] ();

    logic [int_rs_pkg::PHY_IDX-1:0] rs1_phy;
    logic [int_rs_pkg::PHY_IDX-1:0] rs2_phy;
    logic [int_rs_pkg::XLEN-1:0]    rs1_value;
    logic [int_rs_pkg::XLEN-1:0]    rs2_value;
    logic                           issue_valid;
    int_rs_pkg::alu_req_t           issue_req;

    // lane 1 from load writeback
    assign cdb[1].valid  = ld_valid;
    assign cdb[1].rob_id = ld_rob_id;
    assign cdb[1].rd_phy = ld_rd_phy;
    assign cdb[1].value  = ld_value;

    assign result_valid  = cdb[0].valid;
    assign result_rob_id = cdb[0].rob_id;
    assign result_rd_phy = cdb[0].rd_phy;
    assign result_value  = cdb[0].value;

    int_rs_ordered u_rs (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_uop    (disp_uop),
        .disp_ready  (disp_ready),
        .cdb         (cdb),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    int_prf u_prf (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_alu u_alu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .cdb         (cdb[0])
    );

endmodule

//--- verilog/fu_alu.sv
module fu_alu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  int_rs_pkg::alu_req_t issue_req,
    cdb_itf.fu                   cdb
);

    logic [int_rs_pkg::XLEN-1:0] op1;
    logic [int_rs_pkg::XLEN-1:0] op2;
    logic [int_rs_pkg::XLEN-1:0] result;

    assign op1 = issue_req.rs1_value;
    assign op2 = (issue_req.op2_sel == int_rs_pkg::OP2_IMM) ? issue_req.imm
                                                            : issue_req.rs2_value;

    always_comb begin
        case (issue_req.op)
            int_rs_pkg::ALU_ADD: result = op1 + op2;
            int_rs_pkg::ALU_SUB: result = op1 - op2;
            int_rs_pkg::ALU_AND: result = op1 & op2;
            int_rs_pkg::ALU_OR:  result = op1 | op2;
            int_rs_pkg::ALU_XOR: result = op1 ^ op2;
            // shift amount from low five bits
            int_rs_pkg::ALU_SLL: result = op1 << op2[4:0];
            int_rs_pkg::ALU_SRL: result = op1 >> op2[4:0];
            int_rs_pkg::ALU_SLT: begin
                result = {{(int_rs_pkg::XLEN - 1){1'b0}}, ($signed(op1) < $signed(op2))};
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_valid;
        end
    end

    // broadcast payload, qualified by valid
    always_ff @(posedge clk) begin
        cdb.rob_id <= issue_req.rob_id;
        cdb.rd_phy <= issue_req.rd_phy;
        cdb.value  <= result;
    end

endmodule

//--- verilog/int_prf.sv
module int_prf (
    input  logic                           clk,
    input  logic                           rst,
    cdb_itf.rs                             cdb [int_rs_pkg::CDB_WIDTH],
    input  logic [int_rs_pkg::PHY_IDX-1:0] rs1_phy,
    input  logic [int_rs_pkg::PHY_IDX-1:0] rs2_phy,
    output logic [int_rs_pkg::XLEN-1:0]    rs1_value,
    output logic [int_rs_pkg::XLEN-1:0]    rs2_value
);

    logic [int_rs_pkg::XLEN-1:0]      regs [int_rs_pkg::PHY_REGS];
    logic [int_rs_pkg::CDB_WIDTH-1:0] lane_valid;
    logic [int_rs_pkg::PHY_IDX-1:0]   lane_tag   [int_rs_pkg::CDB_WIDTH];
    logic [int_rs_pkg::XLEN-1:0]      lane_value [int_rs_pkg::CDB_WIDTH];

    generate for (genvar l = 0; l < int_rs_pkg::CDB_WIDTH; l++) begin : g_lane
        assign lane_valid[l] = cdb[l].valid;
        assign lane_tag[l]   = cdb[l].rd_phy;
        assign lane_value[l] = cdb[l].value;
    end endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < int_rs_pkg::PHY_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < int_rs_pkg::CDB_WIDTH; l++) begin
                if (lane_valid[l]) begin
                    regs[lane_tag[l]] <= lane_value[l];
                end
            end
        end
    end

    assign rs1_value = regs[rs1_phy];
    assign rs2_value = regs[rs2_phy];

    // alu and load port never target one tag together
    a_no_dual_write: assert property (@(posedge clk) disable iff (rst)
        !(lane_valid[0] && lane_valid[1] && lane_tag[0] == lane_tag[1]));

endmodule

//--- verilog/int_rs_ordered.sv
module int_rs_ordered (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [int_rs_pkg::DISPATCH_WIDTH-1:0] disp_valid,
    input  int_rs_pkg::rs_entry_t                 disp_uop [int_rs_pkg::DISPATCH_WIDTH],
    output logic                                  disp_ready,
    cdb_itf.rs                                    cdb [int_rs_pkg::CDB_WIDTH],
    output logic [int_rs_pkg::PHY_IDX-1:0]        rs1_phy,
    output logic [int_rs_pkg::PHY_IDX-1:0]        rs2_phy,
    input  logic [int_rs_pkg::XLEN-1:0]           rs1_value,
    input  logic [int_rs_pkg::XLEN-1:0]           rs2_value,
    output logic                                  issue_valid,
    output int_rs_pkg::alu_req_t                  issue_req
);

    logic [int_rs_pkg::RS_DEPTH-1:0]       rs_valid;
    logic [int_rs_pkg::RS_DEPTH-1:0]       rs_request;
    logic [int_rs_pkg::RS_DEPTH-1:0]       rs_push_en;
    logic [int_rs_pkg::RS_DEPTH-1:0]       rs_clear;
    int_rs_pkg::rs_entry_t                 rs_entry_q  [int_rs_pkg::RS_DEPTH];
    int_rs_pkg::rs_entry_t                 rs_entry_in [int_rs_pkg::RS_DEPTH];
    int_rs_pkg::rs_entry_t                 push_uop    [int_rs_pkg::RS_DEPTH];
    int_rs_pkg::update_sel_t               update_sel  [int_rs_pkg::RS_DEPTH];
    int_rs_pkg::rs_entry_t                 issued;
    logic                                  pop;
    logic [int_rs_pkg::RS_IDX-1:0]         issue_idx;
    logic [int_rs_pkg::RS_IDX:0]           free_count;
    logic [int_rs_pkg::DISPATCH_WIDTH-1:0] slot_push_en;
    logic [int_rs_pkg::RS_IDX-1:0]         slot_push_idx [int_rs_pkg::DISPATCH_WIDTH];

    generate for (genvar i = 0; i < int_rs_pkg::RS_DEPTH; i++) begin : g_slot
        rs_entry u_entry (
            .clk      (clk),
            .rst      (rst),
            .push_en  (rs_push_en[i]),
            .clear    (rs_clear[i]),
            .entry_in (rs_entry_in[i]),
            .wakeup   (cdb),
            .valid    (rs_valid[i]),
            .request  (rs_request[i]),
            .entry    (rs_entry_q[i])
        );
    end endgenerate

    rs_alloc u_alloc (
        .clk        (clk),
        .rst        (rst),
        .pop        (pop),
        .disp_valid (disp_valid),
        .free_count (free_count),
        .push_en    (slot_push_en),
        .push_idx   (slot_push_idx),
        .ready      (disp_ready)
    );

    ////////////////////////////////////////
    // oldest-first select
    ////////////////////////////////////////

    // scan downward so the lowest index wins
    always_comb begin
        pop       = 1'b0;
        issue_idx = '0;
        for (int i = int_rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (rs_request[i]) begin
                pop       = 1'b1;
                issue_idx = int_rs_pkg::RS_IDX'(i);
            end
        end
    end

    always_comb begin
        free_count = '0;
        for (int i = 0; i < int_rs_pkg::RS_DEPTH; i++) begin
            if (!rs_valid[i]) begin
                free_count = (int_rs_pkg::RS_IDX + 1)'(free_count + 1'b1);
            end
        end
    end

    ////////////////////////////////////////
    // compaction
    ////////////////////////////////////////

    always_comb begin : compress_control
        for (int i = 0; i < int_rs_pkg::RS_DEPTH; i++) begin
            update_sel[i] = int_rs_pkg::SELF;
            push_uop[i]   = disp_uop[0];
            if (pop && int_rs_pkg::RS_IDX'(i) >= issue_idx) begin
                update_sel[i] = int_rs_pkg::PREV;
            end
            // push overrides a shift into the same slot
            for (int w = 0; w < int_rs_pkg::DISPATCH_WIDTH; w++) begin
                if (slot_push_en[w] && slot_push_idx[w] == int_rs_pkg::RS_IDX'(i)) begin
                    update_sel[i] = int_rs_pkg::PUSH_IN;
                    push_uop[i]   = disp_uop[w];
                end
            end
        end
    end

    always_comb begin : compress_mux
        int above;
        for (int i = 0; i < int_rs_pkg::RS_DEPTH; i++) begin
            above          = (i < int_rs_pkg::RS_DEPTH - 1) ? i + 1 : i;
            rs_push_en[i]  = 1'b0;
            rs_clear[i]    = 1'b0;
            rs_entry_in[i] = push_uop[i];
            case (update_sel[i])
                int_rs_pkg::PREV: begin
                    if (i < int_rs_pkg::RS_DEPTH - 1) begin
                        rs_push_en[i]  = rs_valid[above];
                        rs_clear[i]    = !rs_valid[above];
                        rs_entry_in[i] = rs_entry_q[above];
                    end else begin
                        rs_clear[i] = 1'b1;
                    end
                end
                int_rs_pkg::PUSH_IN: begin
                    rs_push_en[i] = 1'b1;
                end
                default: begin
                    rs_push_en[i] = 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // operand read and issue payload
    ////////////////////////////////////////

    assign issued      = rs_entry_q[issue_idx];
    assign rs1_phy     = issued.rs1_phy;
    assign rs2_phy     = issued.rs2_phy;
    assign issue_valid = pop;

    always_comb begin
        issue_req.rob_id    = issued.rob_id;
        issue_req.rd_phy    = issued.rd_phy;
        issue_req.op        = issued.op;
        issue_req.op2_sel   = issued.op2_sel;
        issue_req.imm       = issued.imm;
        issue_req.rs1_value = rs1_value;
        issue_req.rs2_value = rs2_value;
    end

    // dispatcher must hold off while the station is nearly full
    a_disp_when_ready: assert property (@(posedge clk) disable iff (rst)
        |disp_valid |-> disp_ready);

endmodule

//--- verilog/rs_alloc.sv
module rs_alloc (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   pop,
    input  logic [int_rs_pkg::DISPATCH_WIDTH-1:0]  disp_valid,
    input  logic [int_rs_pkg::RS_IDX:0]            free_count,
    output logic [int_rs_pkg::DISPATCH_WIDTH-1:0]  push_en,
    output logic [int_rs_pkg::RS_IDX-1:0]          push_idx [int_rs_pkg::DISPATCH_WIDTH],
    output logic                                   ready
);

    // one extra bit so a full queue can point past the last slot
    logic [int_rs_pkg::RS_IDX:0] top_ptr;
    logic [int_rs_pkg::RS_IDX:0] top_next;

    assign ready = free_count >= (int_rs_pkg::RS_IDX + 1)'(int_rs_pkg::DISPATCH_WIDTH);

    always_comb begin
        top_next = top_ptr;
        if (pop) begin
            top_next = (int_rs_pkg::RS_IDX + 1)'(top_next - 1'b1);
        end
        for (int w = 0; w < int_rs_pkg::DISPATCH_WIDTH; w++) begin
            push_en[w]  = 1'b0;
            push_idx[w] = '0;
            if (disp_valid[w] && ready) begin
                push_en[w]  = 1'b1;
                push_idx[w] = top_next[int_rs_pkg::RS_IDX-1:0];
                top_next    = (int_rs_pkg::RS_IDX + 1)'(top_next + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
        end else begin
            top_ptr <= top_next;
        end
    end

    a_top_bound: assert property (@(posedge clk) disable iff (rst)
        top_ptr <= (int_rs_pkg::RS_IDX + 1)'(int_rs_pkg::RS_DEPTH));

endmodule

//--- verilog/rs_entry.sv
module rs_entry (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_en,
    input  logic                  clear,
    input  int_rs_pkg::rs_entry_t entry_in,
    cdb_itf.rs                    wakeup [int_rs_pkg::CDB_WIDTH],
    output logic                  valid,
    output logic                  request,
    output int_rs_pkg::rs_entry_t entry
);

    logic [int_rs_pkg::CDB_WIDTH-1:0] lane_valid;
    logic [int_rs_pkg::PHY_IDX-1:0]   lane_tag [int_rs_pkg::CDB_WIDTH];
    logic                             held_hit1;
    logic                             held_hit2;
    logic                             in_hit1;
    logic                             in_hit2;
    int_rs_pkg::rs_entry_t            load_entry;

    generate for (genvar l = 0; l < int_rs_pkg::CDB_WIDTH; l++) begin : g_lane
        assign lane_valid[l] = wakeup[l].valid;
        assign lane_tag[l]   = wakeup[l].rd_phy;
    end endgenerate

    // tag match against both the held and the incoming sources
    always_comb begin
        held_hit1 = 1'b0;
        held_hit2 = 1'b0;
        in_hit1   = 1'b0;
        in_hit2   = 1'b0;
        for (int l = 0; l < int_rs_pkg::CDB_WIDTH; l++) begin
            if (lane_valid[l]) begin
                held_hit1 |= (lane_tag[l] == entry.rs1_phy);
                held_hit2 |= (lane_tag[l] == entry.rs2_phy);
                in_hit1   |= (lane_tag[l] == entry_in.rs1_phy);
                in_hit2   |= (lane_tag[l] == entry_in.rs2_phy);
            end
        end
        load_entry           = entry_in;
        load_entry.rs1_ready = entry_in.rs1_ready | in_hit1;
        load_entry.rs2_ready = entry_in.rs2_ready | in_hit2;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= 1'b0;
        end else if (push_en) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            entry <= load_entry;
        end else begin
            entry.rs1_ready <= entry.rs1_ready | held_hit1;
            entry.rs2_ready <= entry.rs2_ready | held_hit2;
        end
    end

    assign request = valid && entry.rs1_ready &&
                     (entry.rs2_ready || entry.op2_sel == int_rs_pkg::OP2_IMM);

    // compaction control never loads and empties one slot at once
    a_push_clear_excl: assert property (@(posedge clk) disable iff (rst)
        !(push_en && clear));

endmodule

//--- verilog/cdb_itf.sv
interface cdb_itf;

    logic                           valid;
    logic [int_rs_pkg::ROB_IDX-1:0] rob_id;
    logic [int_rs_pkg::PHY_IDX-1:0] rd_phy;
    logic [int_rs_pkg::XLEN-1:0]    value;

    // producing unit
    modport fu (
        output valid, rob_id, rd_phy, value
    );

    // station and register file
    modport rs (
        input valid, rob_id, rd_phy, value
    );

endinterface

//--- verilog/int_rs_pkg.sv
package int_rs_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////

    localparam int XLEN           = 32;
    localparam int PHY_REGS       = 64;
    localparam int PHY_IDX        = 6;
    localparam int ROB_IDX        = 5;
    localparam int ARCH_IDX       = 5;
    localparam int RS_DEPTH       = 8;
    localparam int RS_IDX         = 3;
    localparam int DISPATCH_WIDTH = 2;
    // lane 0 alu, lane 1 load writeback
    localparam int CDB_WIDTH      = 2;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_t;

    // per-slot source for the compacting queue
    typedef enum logic [1:0] {
        SELF,
        PREV,
        PUSH_IN
    } update_sel_t;

    typedef struct packed {
        logic [ROB_IDX-1:0]  rob_id;
        logic [PHY_IDX-1:0]  rs1_phy;
        logic                rs1_ready;
        logic [PHY_IDX-1:0]  rs2_phy;
        logic                rs2_ready;
        logic [PHY_IDX-1:0]  rd_phy;
        logic [ARCH_IDX-1:0] rd_arch;
        op2_sel_t            op2_sel;
        logic [XLEN-1:0]     imm;
        alu_op_t             op;
    } rs_entry_t;

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        alu_op_t            op;
        op2_sel_t           op2_sel;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    rs1_value;
        logic [XLEN-1:0]    rs2_value;
    } alu_req_t;

endpackage
